/* Makefile */
# Verilator build for the GPIO bridge testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_gpio_bridge
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_gpio_bridge.sv */
/*
 * Testbench for the GPIO bridge top
 * A UART host model drives commands and checks replies and pin registers
 */
`timescale 1ns/1ns
`default_nettype none

module tb_gpio_bridge import gpio_bridge_pkg::*; ();

  logic              clk;
  logic              rst_n;
  logic              host_tx;
  logic              dut_tx;
  logic [GPIO_W-1:0] pins_in;
  logic [GPIO_W-1:0] pins_out;
  logic [GPIO_W-1:0] pins_oe;

  // Reference model of the pin registers
  logic [GPIO_W-1:0] exp_out;
  logic [GPIO_W-1:0] exp_oe;
  logic [31:0]       lfsr_state;
  logic [15:0]       rnd;
  logic              found;

  gpio_bridge_top UUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .uart_rx_i (host_tx),
    .uart_tx_o (dut_tx),
    .gpio_i    (pins_in),
    .gpio_o    (pins_out),
    .gpio_oe_o (pins_oe)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois form shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run aborted");
  endtask

  // Every task starts and ends 2 ns after a rising edge
  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // Leading idle half bit finishes the previous stop bit
  task automatic send_byte(input logic [7:0] data, input logic stop_level);
    logic [9:0] frame;
    frame = {stop_level, data, 1'b0};
    host_tx = 1'b1;
    step_cycles(HALF_BIT);
    for (int i = 0; i < 9; i++) begin
      host_tx = frame[i];
      step_cycles(CLKS_PER_BIT);
    end
    host_tx = stop_level;
    if (stop_level) begin
      step_cycles(HALF_BIT);
    end else begin
      step_cycles(CLKS_PER_BIT);
      host_tx = 1'b1;
    end
  endtask

  task automatic wait_start(input int max_cycles, output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < max_cycles) begin
      if (dut_tx === 1'b0) begin
        seen = 1'b1;
      end else begin
        step_cycles(1);
        n++;
      end
    end
  endtask

  task automatic receive_byte(output logic [7:0] data);
    logic seen;
    data = '0;
    wait_start(4 * CLKS_PER_BIT, seen);
    if (!seen) begin
      abort_run("Timeout while waiting for a reply start bit on uart_tx_o");
    end
    step_cycles(HALF_BIT);
    check_value("uart_tx_o start bit", 16'(dut_tx), 16'h0);
    for (int i = 0; i < 8; i++) begin
      step_cycles(CLKS_PER_BIT);
      data[i] = dut_tx;
    end
    step_cycles(CLKS_PER_BIT);
    check_value("uart_tx_o stop bit", 16'(dut_tx), 16'h1);
  endtask

  task automatic check_pins();
    check_value("gpio_o", pins_out, exp_out);
    check_value("gpio_oe_o", pins_oe, exp_oe);
  endtask

  task automatic write_reg(input logic is_oe, input logic [15:0] value);
    logic [7:0] reply;
    send_byte(is_oe ? OP_WRITE_OE : OP_WRITE_OUT, 1'b1);
    send_byte(value[15:8], 1'b1);
    send_byte(value[7:0], 1'b1);
    receive_byte(reply);
    check_value("uart_tx_o write reply", 16'(reply), 16'(ACK_BYTE));
    if (is_oe) begin
      exp_oe = value;
    end else begin
      exp_out = value;
    end
    check_pins();
  endtask

  // Pins settle well before the opcode reaches the DUT
  task automatic read_pins(input logic [15:0] value);
    logic [7:0] hi;
    logic [7:0] lo;
    pins_in = value;
    step_cycles(4);
    send_byte(OP_READ, 1'b1);
    receive_byte(hi);
    receive_byte(lo);
    check_value("uart_tx_o read reply high", 16'(hi), 16'(value[15:8]));
    check_value("uart_tx_o read reply low", 16'(lo), 16'(value[7:0]));
    check_pins();
  endtask

  task automatic send_unknown();
    logic [15:0] val;
    logic [7:0]  reply;
    do begin
      draw_bits(8, val);
    end while (val[7:0] == OP_WRITE_OUT || val[7:0] == OP_WRITE_OE ||
               val[7:0] == OP_READ);
    send_byte(val[7:0], 1'b1);
    receive_byte(reply);
    check_value("uart_tx_o unknown opcode reply", 16'(reply), 16'(NAK_BYTE));
    check_pins();
  endtask

  initial begin
    lfsr_state = 32'h7147_3afd;
    exp_out    = '0;
    exp_oe     = '0;
    host_tx    = 1'b1;
    pins_in    = '0;
    rst_n      = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step_cycles(2);

    check_pins();
    check_value("uart_tx_o idle", 16'(dut_tx), 16'h1);

    for (int i = 0; i < 8; i++) begin
      draw_bits(16, rnd);
      write_reg(1'b0, rnd);
    end
    for (int i = 0; i < 8; i++) begin
      draw_bits(16, rnd);
      write_reg(1'b1, rnd);
    end
    for (int i = 0; i < 6; i++) begin
      draw_bits(16, rnd);
      read_pins(rnd);
    end
    for (int i = 0; i < 6; i++) begin
      send_unknown();
    end

    // Read opcode with a broken stop bit must be dropped
    send_byte(OP_READ, 1'b0);
    wait_start(15 * CLKS_PER_BIT, found);
    if (found) begin
      abort_run("Reply seen after a frame with a low stop bit");
    end
    draw_bits(16, rnd);
    read_pins(rnd);
    draw_bits(16, rnd);
    write_reg(1'b0, rnd);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* common/gpio_bridge_pkg.sv */
/*
 * GPIO bridge package: UART bit timing, reply bytes, opcodes and command states
 */
`default_nettype none

package gpio_bridge_pkg;

  // UART bit timing in clock cycles
  localparam int CLKS_PER_BIT = 16;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int BIT_TMR_W    = $clog2(CLKS_PER_BIT);

  // Number of general-purpose pins
  localparam int GPIO_W = 16;

  // Single-byte replies
  localparam logic [7:0] ACK_BYTE = 8'h06;
  localparam logic [7:0] NAK_BYTE = 8'h15;

  // Host command opcodes, ASCII 'W', 'E' and 'R'
  typedef enum logic [7:0] {
    OP_WRITE_OUT = 8'h57,
    OP_WRITE_OE  = 8'h45,
    OP_READ      = 8'h52
  } opcode_e;

  typedef enum logic [2:0] {
    IDLE,
    DATA_HI,
    DATA_LO,
    REPLY,
    REPLY_WAIT,
    REPLY2
  } cmd_state_e;

endpackage

`default_nettype wire

/* common/uart_if.sv */
/*
 * UART link between the receiver, the transmitter and the command controller
 */
`timescale 1ns/1ns
`default_nettype none

interface uart_if;

  logic [7:0] rx_data;
  logic       rx_valid;
  logic [7:0] tx_data;
  logic       tx_start;
  logic       tx_busy;

  modport rx_side (output rx_data, output rx_valid);

  modport tx_side (input tx_data, input tx_start, output tx_busy);

  modport ctrl (
    input  rx_data,
    input  rx_valid,
    input  tx_busy,
    output tx_data,
    output tx_start
  );

endinterface

`default_nettype wire

/* flist.f */
common/gpio_bridge_pkg.sv
common/uart_if.sv
uart/bit_timer.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/cmd_ctrl.sv
hdl/pad_ctrl.sv
hdl/gpio_bridge_top.sv
bench/tb_gpio_bridge.sv

/* hdl/cmd_ctrl.sv */
/*
 * Command controller: decodes host opcodes, collects write data,
 * strobes the pin registers and sends ACK, NAK or read data back
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_ctrl import gpio_bridge_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  uart_if.ctrl              uart,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output logic              wr_out_o,
  output logic              wr_oe_o,
  output logic [GPIO_W-1:0] wr_data_o
);

  cmd_state_e        state_q;
  opcode_e           opcode;
  logic              is_oe_q;
  logic              second_q;
  logic              wr_out_q;
  logic              wr_oe_q;
  logic              tx_start_q;
  logic [7:0]        tx_data_q;
  logic [7:0]        data_hi_q;
  logic [GPIO_W-1:0] wr_data_q;
  // First reply byte in the upper half
  logic [15:0]       reply_q;
  logic              tx_idle;

  assign opcode = opcode_e'(uart.rx_data);

  // Busy rises one cycle after the start strobe, so both must be low
  assign tx_idle = !tx_start_q && !uart.tx_busy;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      is_oe_q    <= 1'b0;
      second_q   <= 1'b0;
      wr_out_q   <= 1'b0;
      wr_oe_q    <= 1'b0;
      tx_start_q <= 1'b0;
    end else begin
      wr_out_q   <= 1'b0;
      wr_oe_q    <= 1'b0;
      tx_start_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (uart.rx_valid) begin
            case (opcode)
              OP_WRITE_OUT: begin
                is_oe_q <= 1'b0;
                state_q <= DATA_HI;
              end
              OP_WRITE_OE: begin
                is_oe_q <= 1'b1;
                state_q <= DATA_HI;
              end
              OP_READ: begin
                second_q <= 1'b1;
                state_q  <= REPLY;
              end
              default: begin
                second_q <= 1'b0;
                state_q  <= REPLY;
              end
            endcase
          end
        end
        DATA_HI: begin
          if (uart.rx_valid) begin
            state_q <= DATA_LO;
          end
        end
        DATA_LO: begin
          if (uart.rx_valid) begin
            wr_out_q <= !is_oe_q;
            wr_oe_q  <= is_oe_q;
            second_q <= 1'b0;
            state_q  <= REPLY;
          end
        end
        REPLY: begin
          if (tx_idle) begin
            tx_start_q <= 1'b1;
            state_q    <= REPLY_WAIT;
          end
        end
        REPLY_WAIT: begin
          if (tx_idle) begin
            state_q <= second_q ? REPLY2 : IDLE;
          end
        end
        REPLY2: begin
          tx_start_q <= 1'b1;
          second_q   <= 1'b0;
          state_q    <= REPLY_WAIT;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Data path, loaded alongside the control transitions above
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (uart.rx_valid) begin
          if (opcode == OP_READ) begin
            reply_q <= gpio_in_i;
          end else begin
            reply_q <= {NAK_BYTE, 8'h00};
          end
        end
      end
      DATA_HI: begin
        if (uart.rx_valid) begin
          data_hi_q <= uart.rx_data;
        end
      end
      DATA_LO: begin
        if (uart.rx_valid) begin
          wr_data_q <= {data_hi_q, uart.rx_data};
          reply_q   <= {ACK_BYTE, 8'h00};
        end
      end
      REPLY: begin
        if (tx_idle) begin
          tx_data_q <= reply_q[15:8];
        end
      end
      REPLY2: tx_data_q <= reply_q[7:0];
      default: ;
    endcase
  end

  assign wr_out_o      = wr_out_q;
  assign wr_oe_o       = wr_oe_q;
  assign wr_data_o     = wr_data_q;
  assign uart.tx_start = tx_start_q;
  assign uart.tx_data  = tx_data_q;

endmodule

`default_nettype wire

/* hdl/gpio_bridge_top.sv */
/*
 * Board top: host drives and reads 16 GPIO pins through a UART command bridge
 */
`timescale 1ns/1ns
`default_nettype none

module gpio_bridge_top import gpio_bridge_pkg::*; (
  // Clock and reset
  input  logic              clk_i,
  input  logic              rst_n_i,
  // UART
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  // GPIO, split into input, output and enable
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o
);

  logic              rx_line;
  logic [GPIO_W-1:0] gpio_in;
  logic              wr_out;
  logic              wr_oe;
  logic [GPIO_W-1:0] wr_data;

  uart_if uart_bus ();

  pad_ctrl u_pad_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .uart_rx_i (uart_rx_i),
    .gpio_i    (gpio_i),
    .wr_out_i  (wr_out),
    .wr_oe_i   (wr_oe),
    .wr_data_i (wr_data),
    .rx_line_o (rx_line),
    .gpio_in_o (gpio_in),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  uart_rx u_uart_rx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rx_line_i (rx_line),
    .uart      (uart_bus.rx_side)
  );

  uart_tx u_uart_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .uart      (uart_bus.tx_side),
    .tx_line_o (uart_tx_o)
  );

  cmd_ctrl u_cmd_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .uart      (uart_bus.ctrl),
    .gpio_in_i (gpio_in),
    .wr_out_o  (wr_out),
    .wr_oe_o   (wr_oe),
    .wr_data_o (wr_data)
  );

endmodule

`default_nettype wire

/* hdl/pad_ctrl.sv */
/*
 * Pad controller: pin output and enable registers,
 * two-flop synchronizers for the UART line and the pin inputs
 */
`timescale 1ns/1ns
`default_nettype none

module pad_ctrl import gpio_bridge_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              uart_rx_i,
  input  logic [GPIO_W-1:0] gpio_i,
  input  logic              wr_out_i,
  input  logic              wr_oe_i,
  input  logic [GPIO_W-1:0] wr_data_i,
  output logic              rx_line_o,
  output logic [GPIO_W-1:0] gpio_in_o,
  output logic              [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe_o
);

  logic [1:0]        rx_sync_q;
  logic [GPIO_W-1:0] gpio_meta_q;
  logic [GPIO_W-1:0] gpio_sync_q;

  // Idle UART line is high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], uart_rx_i};
    end
  end

  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
  end

  // Pin registers, pins start as inputs driving low
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
    end else begin
      if (wr_out_i) begin
        gpio_o <= wr_data_i;
      end
      if (wr_oe_i) begin
        gpio_oe_o <= wr_data_i;
      end
    end
  end

  assign rx_line_o = rx_sync_q[1];
  assign gpio_in_o = gpio_sync_q;

endmodule

`default_nettype wire

/* uart/bit_timer.sv */
/*
 * Bit timer: ticks at half or full bit period after run rises,
 * then once per bit period until run falls
 */
`timescale 1ns/1ns
`default_nettype none

module bit_timer import gpio_bridge_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic run_i,
  input  logic half_i,
  output logic tick_o
);

  logic                 run_q;
  logic [BIT_TMR_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q <= 1'b0;
      cnt_q <= '0;
    end else if (!run_i) begin
      run_q <= 1'b0;
      cnt_q <= '0;
    end else if (!run_q) begin
      // First run cycle already counts, hence the extra one off
      run_q <= 1'b1;
      cnt_q <= half_i ? BIT_TMR_W'(HALF_BIT - 2) : BIT_TMR_W'(CLKS_PER_BIT - 2);
    end else if (cnt_q == '0) begin
      cnt_q <= BIT_TMR_W'(CLKS_PER_BIT - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign tick_o = run_i && run_q && (cnt_q == '0);

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
/*
 * UART receiver, 8N1, LSB first
 * Samples mid-bit and flags each byte whose stop bit is high
 */
`timescale 1ns/1ns
`default_nettype none

module uart_rx import gpio_bridge_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    rx_line_i,
  uart_if.rx_side uart
);

  logic       line_q;
  logic       active_q;
  logic [3:0] bit_idx_q;
  logic       valid_q;
  logic [7:0] shift_q;
  logic [7:0] data_q;
  logic       tick;

  // Half mode so every tick lands in the middle of a bit
  bit_timer u_bit_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .run_i   (active_q),
    .half_i  (1'b1),
    .tick_o  (tick)
  );

  // Bit index: 0 start, 1..8 data, 9 stop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_q    <= 1'b1;
      active_q  <= 1'b0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      line_q  <= rx_line_i;
      valid_q <= 1'b0;
      if (!active_q) begin
        if (line_q && !rx_line_i) begin
          active_q  <= 1'b1;
          bit_idx_q <= '0;
        end
      end else if (tick) begin
        if (bit_idx_q == 4'd0) begin
          // Line back high at mid start bit, treat as a glitch
          if (rx_line_i) begin
            active_q <= 1'b0;
          end else begin
            bit_idx_q <= 4'd1;
          end
        end else if (bit_idx_q == 4'd9) begin
          active_q <= 1'b0;
          valid_q  <= rx_line_i;
        end else begin
          bit_idx_q <= bit_idx_q + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q && tick) begin
      if (bit_idx_q != 4'd0 && bit_idx_q != 4'd9) begin
        shift_q <= {rx_line_i, shift_q[7:1]};
      end
      // Framing error leaves the last good byte in place
      if (bit_idx_q == 4'd9 && rx_line_i) begin
        data_q <= shift_q;
      end
    end
  end

  assign uart.rx_data  = data_q;
  assign uart.rx_valid = valid_q;

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
/*
 * UART transmitter, 8N1, LSB first
 * Sends one byte per start strobe and reports busy for the whole frame
 */
`timescale 1ns/1ns
`default_nettype none

module uart_tx import gpio_bridge_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  uart_if.tx_side uart,
  output logic    tx_line_o
);

  logic [9:0] frame_q;
  logic [3:0] bit_idx_q;
  logic       busy_q;
  logic       tick;

  bit_timer u_bit_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .run_i   (busy_q),
    .half_i  (1'b0),
    .tick_o  (tick)
  );

  // Bit 0 of the frame drives the line, all ones when idle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_q   <= '1;
      bit_idx_q <= '0;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (uart.tx_start) begin
        frame_q   <= {1'b1, uart.tx_data, 1'b0};
        bit_idx_q <= '0;
        busy_q    <= 1'b1;
      end
    end else if (tick) begin
      frame_q <= {1'b1, frame_q[9:1]};
      // Tenth tick closes the stop bit
      if (bit_idx_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
      end
    end
  end

  assign tx_line_o    = frame_q[0];
  assign uart.tx_busy = busy_q;

endmodule

`default_nettype wire
